// ==== memory_subsystem.f ====
src/mem_pkg.sv
src/mem_port_arbiter.sv
src/unaligned_access_ctrl.sv
src/word_ram.sv
src/memory_subsystem.sv
testbench/memory_subsystem_tb.sv

// ==== testbench/memory_subsystem_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module memory_subsystem_tb;
    import mem_pkg::*;

    localparam int SEED        = 34260;
    localparam int TIMEOUT     = 40;
    localparam int MODEL_BYTES = MEM_WORDS * BYTES;
    localparam int RAND_REQS   = 40;
    localparam int MIXED_REQS  = 400;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [31:0]       acc;   // cycle of the accepting edge
        logic [7:0]        lat;   // 0 when not checked
    } expect_t;

    logic              clk;
    logic              arst_n;
    logic              inst_start;
    logic              inst_ready;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] inst;
    logic              inst_valid;
    logic              d_cmd_start;
    logic              d_cmd_ready;
    mem_cmd_t          d_cmd;
    logic [DATA_W-1:0] rdata;
    logic              rdata_valid;

    logic [7:0]        model_mem [MODEL_BYTES];
    expect_t           exp_inst [$];
    expect_t           exp_rdata [$];
    logic [DATA_W-1:0] last_inst;    // held on inst between pulses
    logic [DATA_W-1:0] last_rdata;
    int                cyc;
    logic              check_lat;
    logic              ctrl_hold;   // unaligned store keeps the controller busy a cycle

    memory_subsystem dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic mem_cmd_t make_cmd(input logic wr, input logic [ADDR_W-1:0] addr,
                                          input logic [DATA_W-1:0] wdata,
                                          input logic [DATA_W-1:0] wmask);
        mem_cmd_t c;
        c.write = wr;
        c.addr  = addr;
        c.wdata = wdata;
        c.wmask = wmask;
        return c;
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        for (int i = 0; i < BYTES; i++) begin
            word[8*i +: 8] = model_mem[(addr + i) % MODEL_BYTES];   // little-endian
        end
        return word;
    endfunction

    function automatic void model_write(input mem_cmd_t cmd);
        logic [7:0] m;
        for (int i = 0; i < BYTES; i++) begin
            m = cmd.wmask[8*i +: 8];
            model_mem[(cmd.addr + i) % MODEL_BYTES] =
                (model_mem[(cmd.addr + i) % MODEL_BYTES] & ~m) | (cmd.wdata[8*i +: 8] & m);
        end
    endfunction

    task automatic check_result(input logic is_inst, input logic [DATA_W-1:0] got);
        expect_t e;
        string   name;
        name = is_inst ? "inst" : "rdata";
        assert ((is_inst ? exp_inst.size() : exp_rdata.size()) != 0)
            else abort_run($sformatf("%s_valid pulsed with no request outstanding", name));
        if (is_inst) begin
            e         = exp_inst.pop_front();
            last_inst = e.data;
        end else begin
            e          = exp_rdata.pop_front();
            last_rdata = e.data;
        end
        assert (got === e.data)
            else abort_run($sformatf("ERR %s got %08h expected %08h", name, got, e.data));
        if (e.lat != 0) begin
            assert (cyc - e.acc + 1 == e.lat)
                else abort_run($sformatf("ERR %s_valid latency got %0h expected %0h",
                                         name, cyc - e.acc + 1, e.lat));
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            if (exp_inst.size() != 0 || exp_rdata.size() != 0) begin
                assert (!inst_ready && !d_cmd_ready)
                    else abort_run("arbiter ready while a read result is still outstanding");
            end
            if (inst_valid) begin
                check_result(1'b1, inst);
            end else begin
                assert (inst === last_inst)
                    else abort_run($sformatf("ERR inst got %08h expected %08h",
                                             inst, last_inst));
            end
            if (rdata_valid) begin
                check_result(1'b0, rdata);
            end else begin
                assert (rdata === last_rdata)
                    else abort_run($sformatf("ERR rdata got %08h expected %08h",
                                             rdata, last_rdata));
            end
        end
    end

    // called at 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic issue(input logic do_fetch, input logic [ADDR_W-1:0] f_addr,
                         input logic do_data, input mem_cmd_t cmd);
        int      wait_cnt;
        int      lat_f;
        int      lat_d;
        expect_t f_exp;
        expect_t d_exp;
        wait_cnt = 0;
        while (!inst_ready) begin
            assert (wait_cnt < TIMEOUT) else abort_run("timeout waiting for arbiter ready");
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if (check_lat && ctrl_hold) begin
            @(posedge clk);
            #1;
        end
        assert (d_cmd_ready)
            else abort_run($sformatf("ERR d_cmd_ready got %0h expected 1", d_cmd_ready));
        ctrl_hold = do_data && cmd.write && cmd.addr[1:0] != 2'b00;
        lat_f = (f_addr[1:0] == 2'b00) ? 1 : 2;
        lat_d = (cmd.addr[1:0] == 2'b00) ? 1 : 2;
        f_exp.data = model_read(f_addr);   // fetch goes out before the data cmd
        d_exp.data = model_read(cmd.addr);
        if (do_data && cmd.write) model_write(cmd);
        inst_start  = do_fetch;
        i_addr      = f_addr;
        d_cmd_start = do_data;
        d_cmd       = cmd;
        @(posedge clk);
        #1;
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        f_exp.acc = cyc;
        d_exp.acc = cyc;
        f_exp.lat = check_lat ? lat_f : 0;
        d_exp.lat = !check_lat ? 0 : (do_fetch ? lat_f + lat_d : lat_d);
        if (do_fetch) exp_inst.push_back(f_exp);
        if (do_data && !cmd.write) exp_rdata.push_back(d_exp);
    endtask

    task automatic read_one(input logic as_fetch, input logic [ADDR_W-1:0] addr);
        if (as_fetch) begin
            issue(1'b1, addr, 1'b0, '0);
        end else begin
            issue(1'b0, '0, 1'b1, make_cmd(1'b0, addr, '0, '0));
        end
    endtask

    initial begin
        int                kind;
        int                wait_cnt;
        logic [ADDR_W-1:0] a;
        void'($urandom(SEED));
        cyc         = 0;
        check_lat   = 1'b1;
        ctrl_hold   = 1'b0;
        arst_n      = 1'b0;
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_cmd       = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        assert (inst_ready && d_cmd_ready && !inst_valid && !rdata_valid)
            else abort_run("readies not high or valids not low after reset");

        for (int w = 0; w < MEM_WORDS; w++) begin
            issue(1'b0, '0, 1'b1, make_cmd(1'b1, w * BYTES, $urandom, '1));
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            read_one(1'b0, w * BYTES);
        end
        for (int n = 0; n < RAND_REQS; n++) begin
            read_one(1'($urandom), $urandom & ~32'h3);
        end
        for (int n = 0; n < RAND_REQS; n++) begin
            a      = $urandom;
            a[1:0] = 2'(1 + $urandom % 3);
            read_one(1'($urandom), a);
        end
        for (int off = 1; off < BYTES; off++) begin   // last word spills into word 0
            read_one(1'b0, MODEL_BYTES - off);
            read_one(1'b1, 32'hffff_ffff - off + 1);
        end
        for (int n = 0; n < RAND_REQS; n++) begin
            a = $urandom;
            issue(1'b0, '0, 1'b1, make_cmd(1'b1, a, $urandom, $urandom));
            read_one(1'($urandom), a);
            read_one(1'($urandom), a - 2);
        end
        for (int n = 0; n < RAND_REQS; n++) begin
            issue(1'b1, $urandom, 1'b1, make_cmd(1'($urandom), $urandom, $urandom, $urandom));
        end

        check_lat = 1'b0;   // back-to-back traffic, latency varies
        for (int n = 0; n < MIXED_REQS; n++) begin
            kind = $urandom % 3;
            a    = $urandom;
            if (1'($urandom)) a[1:0] = 2'b00;
            issue(kind != 1, $urandom, kind != 0,
                  make_cmd(1'($urandom), a, $urandom, $urandom));
        end

        wait_cnt = 0;
        while (exp_inst.size() != 0 || exp_rdata.size() != 0) begin
            assert (wait_cnt < TIMEOUT) else abort_run("timeout waiting for read results");
            @(posedge clk);
            wait_cnt++;
        end
        repeat (10) @(posedge clk);   // stray valid pulses show up here
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/memory_subsystem.sv ====
`default_nettype none
`timescale 1ns/10ps

module memory_subsystem (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire                         inst_start,
    output logic                        inst_ready,
    input  wire  [mem_pkg::ADDR_W-1:0]  i_addr,
    output logic [mem_pkg::DATA_W-1:0]  inst,
    output logic                        inst_valid,

    input  wire                         d_cmd_start,
    output logic                        d_cmd_ready,
    input  wire  mem_pkg::mem_cmd_t     d_cmd,
    output logic [mem_pkg::DATA_W-1:0]  rdata,
    output logic                        rdata_valid
);
    import mem_pkg::*;

    logic              mem_cmd_start;
    logic              mem_cmd_ready;
    mem_cmd_t          mem_cmd;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_rdata_valid;

    logic              ram_cmd_start;
    ram_cmd_t          ram_cmd;
    logic [DATA_W-1:0] ram_rdata;
    logic              ram_rdata_valid;

    mem_port_arbiter u_arbiter (
        .clk             (clk),
        .arst_n          (arst_n),
        .inst_start      (inst_start),
        .inst_ready      (inst_ready),
        .i_addr          (i_addr),
        .inst            (inst),
        .inst_valid      (inst_valid),
        .d_cmd_start     (d_cmd_start),
        .d_cmd_ready     (d_cmd_ready),
        .d_cmd           (d_cmd),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_cmd         (mem_cmd),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    unaligned_access_ctrl u_access_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_cmd         (mem_cmd),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .ram_cmd_start   (ram_cmd_start),
        .ram_cmd         (ram_cmd),
        .ram_rdata       (ram_rdata),
        .ram_rdata_valid (ram_rdata_valid)
    );

    word_ram u_ram (
        .clk             (clk),
        .arst_n          (arst_n),
        .ram_cmd_start   (ram_cmd_start),
        .ram_cmd         (ram_cmd),
        .ram_rdata       (ram_rdata),
        .ram_rdata_valid (ram_rdata_valid)
    );

endmodule

`default_nettype wire

// ==== src/word_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module word_ram (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire                         ram_cmd_start,
    input  wire  mem_pkg::ram_cmd_t     ram_cmd,
    output logic [mem_pkg::DATA_W-1:0]  ram_rdata,
    output logic                        ram_rdata_valid
);
    import mem_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              rd_accept;
    logic              wr_accept;

    assign rd_accept = ram_cmd_start && !ram_cmd.write;
    assign wr_accept = ram_cmd_start && ram_cmd.write;

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            for (int b = 0; b < DATA_W; b++) begin
                if (ram_cmd.wmask[b]) begin
                    mem[ram_cmd.index][b] <= ram_cmd.wdata[b];   // masked bits only
                end
            end
        end
        if (rd_accept) begin
            ram_rdata <= mem[ram_cmd.index];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_rdata_valid <= 1'b0;
        end else begin
            ram_rdata_valid <= rd_accept;
        end
    end

    // an unknown index would write no word or the wrong one
    a_cmd_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        ram_cmd_start |-> !$isunknown({ram_cmd.write, ram_cmd.index})
    );

endmodule

`default_nettype wire

// ==== src/unaligned_access_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module unaligned_access_ctrl (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire                         mem_cmd_start,
    output logic                        mem_cmd_ready,
    input  wire  mem_pkg::mem_cmd_t     mem_cmd,
    output logic [mem_pkg::DATA_W-1:0]  mem_rdata,
    output logic                        mem_rdata_valid,

    output logic                        ram_cmd_start,
    output mem_pkg::ram_cmd_t           ram_cmd,
    input  wire  [mem_pkg::DATA_W-1:0]  ram_rdata,
    input  wire                         ram_rdata_valid
);
    import mem_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_HIGH
    } state_t;

    state_t            state;
    logic              accept;
    logic              unaligned;
    logic [OFF_W-1:0]  off;
    logic [IDX_W-1:0]  idx;
    logic [SH_W-1:0]   lo_sh;
    logic [SH_W-1:0]   hi_sh;
    ram_cmd_t          lo_cmd;
    ram_cmd_t          hi_cmd;
    ram_cmd_t          hi_q;       // second half, issued the cycle after accept
    logic              lo_pend;    // next ram read data is a low half
    logic [OFF_W-1:0]  rd_off_q;
    logic [SH_W-1:0]   rd_lo_sh;
    logic [SH_W-1:0]   rd_hi_sh;
    logic [DATA_W-1:0] lo_q;

    assign mem_cmd_ready = (state == ST_IDLE);
    assign accept        = mem_cmd_start && mem_cmd_ready;

    assign off       = mem_cmd.addr[OFF_W-1:0];
    assign idx       = mem_cmd.addr[OFF_W +: IDX_W];
    assign unaligned = (off != '0);
    assign lo_sh     = {1'b0, off, 3'b000};
    assign hi_sh     = SH_W'(DATA_W) - lo_sh;

    // low word takes the bytes from off upward, high word gets the spill
    always_comb begin
        lo_cmd.write = mem_cmd.write;
        lo_cmd.index = idx;
        lo_cmd.wdata = mem_cmd.wdata << lo_sh;
        lo_cmd.wmask = mem_cmd.wmask << lo_sh;

        hi_cmd.write = mem_cmd.write;
        hi_cmd.index = idx + 1'b1;              // wraps at MEM_WORDS
        hi_cmd.wdata = mem_cmd.wdata >> hi_sh;
        hi_cmd.wmask = mem_cmd.wmask >> hi_sh;
    end

    always_comb begin
        ram_cmd_start = 1'b0;
        ram_cmd       = lo_cmd;
        if (state == ST_HIGH) begin
            ram_cmd_start = 1'b1;
            ram_cmd       = hi_q;
        end else if (mem_cmd_start) begin
            ram_cmd_start = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            lo_pend  <= 1'b0;
            rd_off_q <= '0;
        end else begin
            lo_pend <= accept && unaligned && !mem_cmd.write;
            if (accept && !mem_cmd.write) begin
                rd_off_q <= off;
            end
            case (state)
                ST_IDLE: begin
                    if (accept && unaligned) begin
                        state <= ST_HIGH;
                    end
                end
                ST_HIGH: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign rd_lo_sh = {1'b0, rd_off_q, 3'b000};
    assign rd_hi_sh = SH_W'(DATA_W) - rd_lo_sh;

    always_ff @(posedge clk) begin
        if (accept) begin
            hi_q <= hi_cmd;
        end
        if (ram_rdata_valid && lo_pend) begin
            lo_q <= ram_rdata >> rd_lo_sh;   // bytes at off..3 moved down
        end
    end

    assign mem_rdata_valid = ram_rdata_valid && !lo_pend;
    assign mem_rdata       = (rd_off_q == '0) ? ram_rdata
                                              : (lo_q | (ram_rdata << rd_hi_sh));

    // the arbiter must see ready low and hold off while the high half goes out
    a_no_start_in_high: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == ST_HIGH) |-> !mem_cmd_start
    );

endmodule

`default_nettype wire

// ==== src/mem_port_arbiter.sv ====
`default_nettype none
`timescale 1ns/10ps

module mem_port_arbiter (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire                         inst_start,
    output logic                        inst_ready,
    input  wire  [mem_pkg::ADDR_W-1:0]  i_addr,
    output logic [mem_pkg::DATA_W-1:0]  inst,
    output logic                        inst_valid,

    input  wire                         d_cmd_start,
    output logic                        d_cmd_ready,
    input  wire  mem_pkg::mem_cmd_t     d_cmd,
    output logic [mem_pkg::DATA_W-1:0]  rdata,
    output logic                        rdata_valid,

    output logic                        mem_cmd_start,
    input  wire                         mem_cmd_ready,
    output mem_pkg::mem_cmd_t           mem_cmd,
    input  wire  [mem_pkg::DATA_W-1:0]  mem_rdata,
    input  wire                         mem_rdata_valid
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_READ
    } state_t;

    state_t            state;
    logic              cmd_is_inst;   // access in flight is a fetch
    logic              save_d_pend;   // data cmd queued behind the fetch
    logic [ADDR_W-1:0] save_i_addr;
    mem_cmd_t          save_d_cmd;
    logic [DATA_W-1:0] inst_q;
    logic [DATA_W-1:0] rdata_q;
    mem_cmd_t          fetch_cmd;
    logic              chain_d;

    assign inst_ready  = (state == ST_IDLE);
    assign d_cmd_ready = (state == ST_IDLE);

    // fetch result arriving with a data cmd waiting behind it
    assign chain_d = (state == ST_WAIT_READ) && mem_rdata_valid && cmd_is_inst && save_d_pend;

    always_comb begin
        fetch_cmd      = '0;
        fetch_cmd.addr = (state == ST_IDLE) ? i_addr : save_i_addr;
    end

    always_comb begin
        mem_cmd_start = 1'b0;
        mem_cmd       = save_d_cmd;
        case (state)
            ST_IDLE: begin
                mem_cmd_start = mem_cmd_ready && (inst_start || d_cmd_start);
                mem_cmd       = inst_start ? fetch_cmd : d_cmd;   // fetch first
            end
            ST_WAIT_READY: begin
                mem_cmd_start = mem_cmd_ready;
                mem_cmd       = cmd_is_inst ? fetch_cmd : save_d_cmd;
            end
            ST_WAIT_READ: begin
                mem_cmd_start = chain_d && mem_cmd_ready;
            end
            default: begin
                mem_cmd_start = 1'b0;
            end
        endcase
    end

    assign inst_valid  = (state == ST_WAIT_READ) && mem_rdata_valid && cmd_is_inst;
    assign rdata_valid = (state == ST_WAIT_READ) && mem_rdata_valid && !cmd_is_inst;

    assign inst  = inst_valid ? mem_rdata : inst_q;
    assign rdata = rdata_valid ? mem_rdata : rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_IDLE;
            cmd_is_inst <= 1'b0;
            save_d_pend <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    save_d_pend <= inst_start && d_cmd_start;
                    if (inst_start) begin
                        cmd_is_inst <= 1'b1;
                        state       <= mem_cmd_ready ? ST_WAIT_READ : ST_WAIT_READY;
                    end else if (d_cmd_start) begin
                        cmd_is_inst <= 1'b0;
                        if (!mem_cmd_ready) begin
                            state <= ST_WAIT_READY;
                        end else if (!d_cmd.write) begin
                            state <= ST_WAIT_READ;
                        end
                    end
                end
                ST_WAIT_READY: begin
                    if (mem_cmd_ready) begin
                        // a store has nothing to wait for
                        state <= (!cmd_is_inst && save_d_cmd.write) ? ST_IDLE : ST_WAIT_READ;
                    end
                end
                ST_WAIT_READ: begin
                    if (chain_d) begin
                        cmd_is_inst <= 1'b0;
                        save_d_pend <= 1'b0;
                        if (!mem_cmd_ready) begin
                            state <= ST_WAIT_READY;
                        end else if (save_d_cmd.write) begin
                            state <= ST_IDLE;
                        end
                    end else if (mem_rdata_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            save_i_addr <= i_addr;
            save_d_cmd  <= d_cmd;
        end
        if (inst_valid) begin
            inst_q <= mem_rdata;
        end
        if (rdata_valid) begin
            rdata_q <= mem_rdata;
        end
    end

    // a result arriving outside wait-read would be dropped
    a_result_expected: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_rdata_valid |-> (state == ST_WAIT_READ)
    );

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int MEM_WORDS = 256;                  // 1 KiB
    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int BYTES     = DATA_W / 8;
    localparam int OFF_W     = $clog2(BYTES);        // byte offset in a word
    localparam int SH_W      = $clog2(DATA_W) + 1;   // bit shift, up to DATA_W

    // byte addressed, data and mask as seen from addr upward
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] wmask;
    } mem_cmd_t;

    // word addressed, data and mask already in word position
    typedef struct packed {
        logic              write;
        logic [IDX_W-1:0]  index;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] wmask;
    } ram_cmd_t;

endpackage

`default_nettype wire
